/* Bender.yml */
package:
  name: board_ctrl

sources:
  # Packages first, then RTL bottom up
  - design/board_pkg.sv
  - design/uart_pkg.sv
  - design/uart_rx.sv
  - design/gpio_port.sv
  - design/cmd_engine.sv
  - design/uart_tx.sv
  - design/board_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/board_top_tb.sv

/* design/board_pkg.sv */
// ==========================================================================
// Board level widths and GPIO vector types
// ==========================================================================

package board_pkg;

  // Number of user LEDs on the board
  localparam int LED_W = 8;

  // Number of DIP switch positions
  localparam int SW_W = 4;

  // --------------------------------------------------------------------------
  // GPIO vector types
  // --------------------------------------------------------------------------

  // LED pattern
  // Bit 0 drives the rightmost LED, a one lights it
  typedef logic [LED_W-1:0] led_t;

  // Switch value
  // Bit 0 is switch position 1, a one means the switch is on
  typedef logic [SW_W-1:0] sw_t;

endpackage

/* design/board_top.sv */
`timescale 1ns/10ps

module board_top (
  input  logic            clk,
  input  logic            i_rst_n,
  input  logic            i_uart_rx,
  output logic            o_uart_tx,
  input  board_pkg::sw_t  i_sw,
  output board_pkg::led_t o_led
);

  // Receiver to engine
  logic                 rx_strobe;
  uart_pkg::rx_byte_t   rx_byte;
  // GPIO to and from engine
  board_pkg::sw_t       sw_sync;
  logic                 led_we;
  board_pkg::led_t      led_wdata;
  // Engine to transmitter
  logic                 tx_start;
  uart_pkg::uart_byte_t tx_byte;
  logic                 tx_busy;

  // ==========================================================================
  // Input side
  // ==========================================================================
  uart_rx u_uart_rx (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_rx     (i_uart_rx),
    .o_strobe (rx_strobe),
    .o_byte   (rx_byte)
  );

  gpio_port u_gpio_port (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_sw      (i_sw),
    .o_sw_sync (sw_sync),
    .i_led_we  (led_we),
    .i_led     (led_wdata),
    .o_led     (o_led)
  );

  // Command processing
  cmd_engine u_cmd_engine (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_rx_strobe (rx_strobe),
    .i_rx_byte   (rx_byte),
    .i_sw        (sw_sync),
    .o_led_we    (led_we),
    .o_led       (led_wdata),
    .o_tx_start  (tx_start),
    .o_tx_byte   (tx_byte),
    .i_tx_busy   (tx_busy)
  );

  // ==========================================================================
  // Output side
  // ==========================================================================
  uart_tx u_uart_tx (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_start (tx_start),
    .i_byte  (tx_byte),
    .o_busy  (tx_busy),
    .o_tx    (o_uart_tx)
  );

endmodule

/* design/cmd_engine.sv */
`timescale 1ns/10ps

module cmd_engine (
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  logic                 i_rx_strobe,
  input  uart_pkg::rx_byte_t   i_rx_byte,
  input  board_pkg::sw_t       i_sw,
  output logic                 o_led_we,
  output board_pkg::led_t      o_led,
  output logic                 o_tx_start,
  output uart_pkg::uart_byte_t o_tx_byte,
  input  logic                 i_tx_busy
);

  typedef enum logic [1:0] {
    CE_IDLE,
    CE_WAIT_DATA,
    CE_REPLY
  } ce_state_t;

  ce_state_t            state;
  uart_pkg::uart_byte_t reply;
  logic                 rx_valid;

  // Receiver already drops bad frames, flag checked once more here
  assign rx_valid = i_rx_strobe && !i_rx_byte.frame_err;

  // ==========================================================================
  // Command FSM
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state <= CE_IDLE;
    end else begin
      case (state)
        CE_IDLE: begin
          if (rx_valid) begin
            // LED write needs a data byte, everything else replies at once
            if (i_rx_byte.data == uart_pkg::CMD_WRITE_LED) begin
              state <= CE_WAIT_DATA;
            end else begin
              state <= CE_REPLY;
            end
          end
        end
        CE_WAIT_DATA: begin
          if (rx_valid) begin
            state <= CE_REPLY;
          end
        end
        CE_REPLY: begin
          // Hold until the transmitter is free
          // Incoming bytes are ignored meanwhile
          if (!i_tx_busy) begin
            state <= CE_IDLE;
          end
        end
        default: state <= CE_IDLE;
      endcase
    end
  end

  // ==========================================================================
  // Reply selection
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (state == CE_IDLE && rx_valid) begin
      case (i_rx_byte.data)
        // Switch value zero-extended to a byte
        uart_pkg::CMD_READ_SW: reply <= uart_pkg::uart_byte_t'(i_sw);
        default:               reply <= uart_pkg::RSP_UNKNOWN;
      endcase
    end else if (state == CE_WAIT_DATA && rx_valid) begin
      reply <= uart_pkg::RSP_OK;
    end
  end

  // LED data goes straight from the received byte
  // Register sits in gpio_port
  assign o_led_we = (state == CE_WAIT_DATA) && rx_valid;
  assign o_led    = board_pkg::led_t'(i_rx_byte.data);

  // Start one cycle after the last strobe when idle
  // Busy rises next cycle, by then the FSM is back in idle
  assign o_tx_start = (state == CE_REPLY) && !i_tx_busy;
  assign o_tx_byte  = reply;

endmodule

/* design/gpio_port.sv */
`timescale 1ns/10ps

module gpio_port (
  input  logic              clk,
  input  logic              i_rst_n,
  input  board_pkg::sw_t    i_sw,
  output board_pkg::sw_t    o_sw_sync,
  input  logic              i_led_we,
  input  board_pkg::led_t   i_led,
  output board_pkg::led_t   o_led
);

  board_pkg::sw_t  sw_meta;
  board_pkg::sw_t  sw_sync;
  board_pkg::led_t led_q;

  // ==========================================================================
  // Switch synchronizer
  // ==========================================================================
  // DIP switches are asynchronous to clk
  // Two stages, value valid two cycles after a change
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      sw_meta <= '0;
      sw_sync <= '0;
    end else begin
      sw_meta <= i_sw;
      sw_sync <= sw_meta;
    end
  end

  assign o_sw_sync = sw_sync;

  // ==========================================================================
  // LED register
  // ==========================================================================
  // All LEDs dark out of reset
  // Loaded on the write strobe, held otherwise
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      led_q <= '0;
    end else if (i_led_we) begin
      led_q <= i_led;
    end
  end

  assign o_led = led_q;

endmodule

/* design/uart_pkg.sv */
// ==========================================================================
// Serial line timing, byte types and command codes
// ==========================================================================

package uart_pkg;

  // Clock cycles per serial bit, also the receiver oversampling ratio
  localparam int CLKS_PER_BIT = 16;
  localparam int CNT_W        = $clog2(CLKS_PER_BIT);
  // 8N1 framing
  localparam int DATA_BITS    = 8;
  localparam int FRAME_BITS   = DATA_BITS + 2;

  // Counter types
  typedef logic [CNT_W-1:0] clk_cnt_t;
  typedef logic [2:0]       data_idx_t;
  typedef logic [3:0]       frame_idx_t;

  // Last cycle of a bit, last cycle of the half bit after the start edge
  localparam clk_cnt_t   BIT_LAST   = clk_cnt_t'(CLKS_PER_BIT - 1);
  localparam clk_cnt_t   HALF_LAST  = clk_cnt_t'(CLKS_PER_BIT / 2 - 1);
  localparam data_idx_t  DATA_LAST  = data_idx_t'(DATA_BITS - 1);
  localparam frame_idx_t FRAME_LAST = frame_idx_t'(FRAME_BITS - 1);

  typedef logic [DATA_BITS-1:0] uart_byte_t;

  // Received byte with framing status
  typedef struct packed {
    uart_byte_t data;
    logic       frame_err;
  } rx_byte_t;

  // Command and reply codes
  localparam uart_byte_t CMD_WRITE_LED = 8'h57;
  localparam uart_byte_t CMD_READ_SW   = 8'h52;
  localparam uart_byte_t RSP_OK        = 8'h4B;
  localparam uart_byte_t RSP_UNKNOWN   = 8'h3F;

endpackage

/* design/uart_rx.sv */
`timescale 1ns/10ps

module uart_rx (
  input  logic               clk,
  input  logic               i_rst_n,
  input  logic               i_rx,
  output logic               o_strobe,
  output uart_pkg::rx_byte_t o_byte
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t             state;
  logic                  rx_meta;
  logic                  rx_sync;
  logic                  rx_prev;
  uart_pkg::clk_cnt_t    clk_cnt;
  uart_pkg::data_idx_t   bit_cnt;
  uart_pkg::uart_byte_t  shreg;
  logic                  frame_err;
  logic                  bit_done;

  // ==========================================================================
  // Line synchronizer
  // ==========================================================================
  // Two flops for metastability, third one for the falling edge
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= i_rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign bit_done = (clk_cnt == uart_pkg::BIT_LAST);

  // ==========================================================================
  // Frame FSM
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state     <= RX_IDLE;
      clk_cnt   <= '0;
      bit_cnt   <= '0;
      o_strobe  <= 1'b0;
      frame_err <= 1'b0;
    end else begin
      o_strobe <= 1'b0;
      case (state)
        RX_IDLE: begin
          clk_cnt <= '0;
          // Edge only, a line stuck low after a bad stop bit is no start
          if (rx_prev && !rx_sync) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          if (clk_cnt == uart_pkg::HALF_LAST) begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            // High again at the center means a glitch
            state   <= rx_sync ? RX_IDLE : RX_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_done) begin
            clk_cnt <= '0;
            if (bit_cnt == uart_pkg::DATA_LAST) begin
              state <= RX_STOP;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_done) begin
            // Low stop bit, byte dropped without a strobe
            o_strobe  <= rx_sync;
            frame_err <= !rx_sync;
            state     <= RX_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // Data bits arrive LSB first, shift in from the top
  always_ff @(posedge clk) begin
    if (state == RX_DATA && bit_done) begin
      shreg <= {rx_sync, shreg[uart_pkg::DATA_BITS-1:1]};
    end
  end

  // Shift register is stable until the next frame's first data bit
  assign o_byte = '{data: shreg, frame_err: frame_err};

endmodule

/* design/uart_tx.sv */
`timescale 1ns/10ps

module uart_tx (
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  logic                 i_start,
  input  uart_pkg::uart_byte_t i_byte,
  output logic                 o_busy,
  output logic                 o_tx
);

  logic [uart_pkg::FRAME_BITS-1:0] shreg;
  uart_pkg::clk_cnt_t              clk_cnt;
  uart_pkg::frame_idx_t            bit_cnt;
  logic                            busy;
  logic                            bit_done;

  assign bit_done = (clk_cnt == uart_pkg::BIT_LAST);

  // ==========================================================================
  // Bit timing
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else if (!busy) begin
      clk_cnt <= '0;
      bit_cnt <= '0;
      // Start request while busy is not expected
      if (i_start) begin
        busy <= 1'b1;
      end
    end else if (bit_done) begin
      clk_cnt <= '0;
      // Stop bit held a full bit time, then release
      if (bit_cnt == uart_pkg::FRAME_LAST) begin
        busy <= 1'b0;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // ==========================================================================
  // Frame shift register
  // ==========================================================================
  // Stop, data LSB first, start at bit 0
  always_ff @(posedge clk) begin
    if (!busy && i_start) begin
      shreg <= {1'b1, i_byte, 1'b0};
    end else if (busy && bit_done) begin
      shreg <= {1'b1, shreg[uart_pkg::FRAME_BITS-1:1]};
    end
  end

  assign o_busy = busy;
  // Line idles high
  assign o_tx   = busy ? shreg[0] : 1'b1;

endmodule

/* src.f */
+incdir+test
design/board_pkg.sv
design/uart_pkg.sv
design/uart_rx.sv
design/gpio_port.sv
design/cmd_engine.sv
design/uart_tx.sv
design/board_top.sv
test/board_top_tb.sv

/* test/board_tb_tasks.svh */
// ==========================================================================
// Serial line tasks
// ==========================================================================

// One 8N1 frame on the receive line, stop bit level selectable
// Called on a falling edge, each bit held a full bit time
// Frames sent one after another follow with no idle gap
task send_byte(input uart_pkg::uart_byte_t value, input logic stop_bit);
  logic [uart_pkg::FRAME_BITS-1:0] frame;
  frame = {stop_bit, value, 1'b0};
  for (int b = 0; b < uart_pkg::FRAME_BITS; b++) begin
    uart_rx_line = frame[b];
    repeat (uart_pkg::CLKS_PER_BIT) @(negedge clk);
  end
  // Back to idle, also after a low stop bit
  uart_rx_line = 1'b1;
endtask

// Waits for a start bit, then samples each bit near its center
task capture_byte(output uart_pkg::uart_byte_t value, output logic valid);
  int   waited;
  logic start_bit;
  logic stop_bit;
  waited = 0;
  value  = '0;
  @(negedge clk);
  // Line idles high, first low sample marks the start bit
  while (uart_tx_line !== 1'b0 && waited < 4 * BYTE_CLKS) begin
    @(negedge clk);
    waited++;
  end
  valid = (uart_tx_line === 1'b0);
  if (!valid) begin
    err_cnt++;
    $display("Timeout at %0t ns: no reply arrived on the serial output", $time);
  end else begin
    repeat (uart_pkg::CLKS_PER_BIT / 2) @(negedge clk);
    start_bit = uart_tx_line;
    // LSB first
    for (int i = 0; i < uart_pkg::DATA_BITS; i++) begin
      repeat (uart_pkg::CLKS_PER_BIT) @(negedge clk);
      value[i] = uart_tx_line;
    end
    repeat (uart_pkg::CLKS_PER_BIT) @(negedge clk);
    stop_bit = uart_tx_line;
    assert (start_bit === 1'b0 && stop_bit === 1'b1)
    else report_error("reply frame has a bad start or stop bit");
  end
endtask

// Command with optional data byte, reply captured in parallel
// Reply starts during the last stop bit, so capture runs alongside
task run_command(input uart_pkg::uart_byte_t cmd, input logic has_data,
                 input uart_pkg::uart_byte_t value,
                 output uart_pkg::uart_byte_t rsp, output logic valid);
  fork
    begin
      send_byte(cmd, 1'b1);
      if (has_data) begin
        send_byte(value, 1'b1);
      end
    end
    capture_byte(rsp, valid);
  join
endtask

/* test/board_top_tb.sv */
`timescale 1ns/10ps

module board_top_tb;

  // One serial frame in clock cycles
  localparam int BYTE_CLKS = uart_pkg::FRAME_BITS * uart_pkg::CLKS_PER_BIT;

  logic                 clk;
  logic                 rst_n;
  logic                 uart_rx_line;
  logic                 uart_tx_line;
  board_pkg::sw_t       sw;
  board_pkg::led_t      led;
  logic                 cmd_started;
  integer               seed;
  int                   err_cnt;
  int                   err_at_start;
  int                   test_cnt;
  int                   test_fail;
  uart_pkg::uart_byte_t data;
  uart_pkg::uart_byte_t reply;
  uart_pkg::uart_byte_t reply2;
  logic                 ok;
  logic                 ok2;
  logic                 line_quiet;
  board_pkg::led_t      led_before;

  board_top dut (
    .clk       (clk),
    .i_rst_n   (rst_n),
    .i_uart_rx (uart_rx_line),
    .o_uart_tx (uart_tx_line),
    .i_sw      (sw),
    .o_led     (led)
  );

  // 100 ns period
  always #50 clk = ~clk;

  `include "board_tb_tasks.svh"

  // Serial output idle and LEDs dark until the first command goes out
  assert property (@(posedge clk) disable iff (!rst_n)
    !cmd_started |-> (uart_tx_line && led == '0))
  else begin
    err_cnt++;
    $display("Error at %0t ns: output active before the first command", $time);
  end

  task report_error(input string msg);
    err_cnt++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  task check_reply(input uart_pkg::uart_byte_t got, input logic valid,
                   input uart_pkg::uart_byte_t exp, input string what);
    // Missing reply already reported by the capture
    if (valid) begin
      assert (got === exp)
      else report_error($sformatf("%s reply %h, expected %h", what, got, exp));
    end
  endtask

  task start_test();
    err_at_start = err_cnt;
  endtask

  task finish_test(input string name);
    test_cnt++;
    if (err_cnt != err_at_start) begin
      test_fail++;
      $display("Test %0d %s: failed", test_cnt, name);
    end else begin
      $display("Test %0d %s: ok", test_cnt, name);
    end
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================
  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    uart_rx_line = 1'b1;
    sw           = '0;
    cmd_started  = 1'b0;
    seed         = 4327;
    err_cnt      = 0;
    err_at_start = 0;
    test_cnt     = 0;
    test_fail    = 0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    // Quiet window for the idle property
    start_test();
    repeat (2 * BYTE_CLKS) @(negedge clk);
    assert (uart_tx_line === 1'b1 && led === '0)
    else report_error("outputs not idle after reset");
    finish_test("idle after reset");
    cmd_started = 1'b1;

    // LED writes with random patterns
    repeat (4) begin
      start_test();
      data = uart_pkg::uart_byte_t'($random(seed));
      run_command(uart_pkg::CMD_WRITE_LED, 1'b1, data, reply, ok);
      check_reply(reply, ok, uart_pkg::RSP_OK, "LED write");
      assert (led === data)
      else report_error($sformatf("LED pattern %h, expected %h", led, data));
      finish_test("LED write");
    end

    // Switch read, zero-extended value
    start_test();
    sw = board_pkg::sw_t'($random(seed));
    run_command(uart_pkg::CMD_READ_SW, 1'b0, 8'h00, reply, ok);
    check_reply(reply, ok, uart_pkg::uart_byte_t'(sw), "switch read");
    finish_test("switch read");

    // Random first byte that is no known command
    start_test();
    data = uart_pkg::CMD_WRITE_LED;
    while (data == uart_pkg::CMD_WRITE_LED || data == uart_pkg::CMD_READ_SW) begin
      data = uart_pkg::uart_byte_t'($random(seed));
    end
    led_before = led;
    run_command(data, 1'b0, 8'h00, reply, ok);
    check_reply(reply, ok, uart_pkg::RSP_UNKNOWN, "unknown command");
    assert (led === led_before)
    else report_error("LED pattern changed by an unknown command");
    finish_test("unknown command");

    // Bad stop bit, then a clean read
    start_test();
    send_byte(uart_pkg::CMD_READ_SW, 1'b0);
    line_quiet = 1'b1;
    repeat (2 * BYTE_CLKS) begin
      @(negedge clk);
      if (uart_tx_line !== 1'b1) begin
        line_quiet = 1'b0;
      end
    end
    assert (line_quiet)
    else report_error("reply sent for a byte with a low stop bit");
    run_command(uart_pkg::CMD_READ_SW, 1'b0, 8'h00, reply, ok);
    check_reply(reply, ok, uart_pkg::uart_byte_t'(sw), "read after framing error");
    finish_test("framing error");

    // Second command lands while the first reply is on the line
    // Frames back to back, second reply waits for busy to drop
    start_test();
    sw = board_pkg::sw_t'($random(seed));
    fork
      begin
        send_byte(uart_pkg::CMD_READ_SW, 1'b1);
        send_byte(8'h41, 1'b1);
      end
      begin
        capture_byte(reply, ok);
        capture_byte(reply2, ok2);
      end
    join
    check_reply(reply, ok, uart_pkg::uart_byte_t'(sw), "first of two");
    check_reply(reply2, ok2, uart_pkg::RSP_UNKNOWN, "second of two");
    finish_test("back to back");

    $display("Tests run %0d, failed %0d, errors %0d", test_cnt, test_fail, err_cnt);
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
